// File: run.sh
#!/usr/bin/env bash
# build the core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module tb_core -o tb_core_sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/tb_core_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

echo "simulation finished cleanly"
exit 0

// File: src.f
+incdir+tb
verilog/rv_isa_pkg.sv
verilog/core_pkg.sv
verilog/fetch_if.sv
verilog/fetch_unit.sv
verilog/fetch_queue.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/exec_unit.sv
verilog/rv_core_top.sv
tb/tb_core.sv

// File: tb/core_model.svh
// reference model: register state, data memory copy and list of expected stores
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

logic [31:0] m_regs [32];
logic [31:0] m_dmem [DMEM_WORDS];
logic [29:0] exp_addr [$];
logic [31:0] exp_data [$];

// data port lane order is byte-reversed
function automatic logic [31:0] swap_bytes(input logic [31:0] w);
	return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic sub,
		input logic [31:0] a, input logic [31:0] b);
	case (f3)
		rv_isa_pkg::F3_ADD_SUB: return sub ? a - b : a + b;
		rv_isa_pkg::F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		rv_isa_pkg::F3_XOR:     return a ^ b;
		rv_isa_pkg::F3_OR:      return a | b;
		default:                return a & b;
	endcase
endfunction

task automatic run_model();
	logic [31:0] w;
	logic [31:0] i_imm;
	logic [31:0] s_imm;
	logic [31:0] addr;
	logic [2:0]  f3;
	logic        alu_f3;
	for (int r = 0; r < 32; r++) begin
		m_regs[r] = '0;
	end
	for (int k = 0; k < DMEM_WORDS; k++) begin
		m_dmem[k] = init_dmem[k];
	end
	for (int pc = 0; pc < PROG_LEN; pc++) begin
		w = prog[pc];
		f3 = w[14:12];
		i_imm = {{20{w[31]}}, w[31:20]};
		s_imm = {{20{w[31]}}, w[31:25], w[11:7]};
		alu_f3 = (f3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111});
		if (w[6:0] == rv_isa_pkg::OPC_OP && alu_f3) begin
			m_regs[w[11:7]] = model_alu(f3, w[25 + rv_isa_pkg::F7_SUB_BIT],
				m_regs[w[19:15]], m_regs[w[24:20]]);
		end else if (w[6:0] == rv_isa_pkg::OPC_OP_IMM && alu_f3) begin
			m_regs[w[11:7]] = model_alu(f3, 1'b0, m_regs[w[19:15]], i_imm);
		end else if (w[6:0] == rv_isa_pkg::OPC_LOAD && f3 == rv_isa_pkg::F3_LW_SW) begin
			addr = m_regs[w[19:15]] + i_imm;
			m_regs[w[11:7]] = swap_bytes(m_dmem[addr[7:2]]);
		end else if (w[6:0] == rv_isa_pkg::OPC_STORE && f3 == rv_isa_pkg::F3_LW_SW) begin
			addr = m_regs[w[19:15]] + s_imm;
			m_dmem[addr[7:2]] = swap_bytes(m_regs[w[24:20]]);
			exp_addr.push_back(addr[31:2]);
			exp_data.push_back(swap_bytes(m_regs[w[24:20]]));
		end
		// x0 reads zero whatever was written
		m_regs[0] = '0;
	end
endtask

`endif

// File: tb/tb_core.sv
// testbench for rv_core_top with random program, memory responders, store checks and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_core;

	localparam int PROG_LEN    = 200;
	localparam int DMEM_WORDS  = 64;
	localparam int CYCLE_LIMIT = PROG_LEN * 12 + 300;

	logic                        clk;
	logic                        rst_n;
	logic                        imem_valid;
	logic                        imem_ready = 1'b0;
	logic [core_pkg::ADDR_W-1:0] imem_addr;
	logic [core_pkg::XLEN-1:0]   imem_rdata;
	logic                        dmem_valid;
	logic                        dmem_ready = 1'b0;
	logic                        dmem_write;
	logic [core_pkg::ADDR_W-1:0] dmem_addr;
	logic [core_pkg::XLEN-1:0]   dmem_wdata;
	logic [core_pkg::XLEN-1:0]   dmem_rdata;

	logic [31:0] prog [PROG_LEN];
	logic [31:0] dmem [DMEM_WORDS];
	logic [31:0] init_dmem [DMEM_WORDS];
	int          store_idx = 0;
	int          cycles = 0;
	logic [31:0] fetch_pc = '0;
	logic        hold_prev = 1'b0;
	logic [31:0] prev_addr;
	logic [31:0] prev_write;
	logic [31:0] prev_wdata;

	`include "core_model.svh"

	rv_core_top DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_valid (imem_valid),
		.imem_ready (imem_ready),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.dmem_valid (dmem_valid),
		.dmem_ready (dmem_ready),
		.dmem_write (dmem_write),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata)
	);

	// ------------------------------------------------------------------------
	// memory responders with read data valid in the handshake cycle

	assign imem_rdata = (imem_addr < PROG_LEN) ? prog[imem_addr[7:0]] : rv_isa_pkg::NOP_WORD;
	assign dmem_rdata = dmem[dmem_addr[5:0]];

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		if (rst_n) begin
			imem_ready <= (($urandom % 4) != 0);
			dmem_ready <= (($urandom % 3) != 0);
			if (dmem_valid && dmem_ready && dmem_write) begin
				dmem[dmem_addr[5:0]] <= dmem_wdata;
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: only %0d of %0d stores seen", store_idx, exp_addr.size());
			$display("Done: errors found");
			$fatal(1);
		end
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
	endfunction

	function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, rv_isa_pkg::F3_LW_SW, imm[4:0], rv_isa_pkg::OPC_STORE};
	endfunction

	// byte offset of a random word in the data array
	function automatic logic [11:0] word_offset();
		return 12'(($urandom % DMEM_WORDS) * 4);
	endfunction

	task automatic build_program();
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] imm;
		int          kind;
		// x7 is not yet written here
		prog[0] = encode_s(word_offset(), 5'd7, 5'd0);
		for (int r = 1; r < 8; r++) begin
			prog[r] = encode_i(12'($urandom), 5'd0, rv_isa_pkg::F3_ADD_SUB, 5'(r),
				rv_isa_pkg::OPC_OP_IMM);
		end
		prog[8] = encode_i(12'h7ff, 5'd1, rv_isa_pkg::F3_ADD_SUB, 5'd0, rv_isa_pkg::OPC_OP_IMM);
		prog[9] = encode_s(word_offset(), 5'd0, 5'd0);
		for (int p = 10; p < PROG_LEN - 8; p++) begin
			rd   = 5'($urandom % 8);
			rs1  = 5'($urandom % 8);
			rs2  = 5'($urandom % 8);
			imm  = 12'($urandom);
			kind = int'($urandom % 14);
			case (kind)
				0:  prog[p] = encode_r(7'h00, rs2, rs1, rv_isa_pkg::F3_ADD_SUB, rd);
				1:  prog[p] = encode_r(7'h20, rs2, rs1, rv_isa_pkg::F3_ADD_SUB, rd);
				2:  prog[p] = encode_r(7'h00, rs2, rs1, rv_isa_pkg::F3_AND, rd);
				3:  prog[p] = encode_r(7'h00, rs2, rs1, rv_isa_pkg::F3_OR, rd);
				4:  prog[p] = encode_r(7'h00, rs2, rs1, rv_isa_pkg::F3_XOR, rd);
				5:  prog[p] = encode_r(7'h00, rs2, rs1, rv_isa_pkg::F3_SLT, rd);
				6:  prog[p] = encode_i(imm, rs1, rv_isa_pkg::F3_ADD_SUB, rd, rv_isa_pkg::OPC_OP_IMM);
				7:  prog[p] = encode_i(imm, rs1, rv_isa_pkg::F3_AND, rd, rv_isa_pkg::OPC_OP_IMM);
				8:  prog[p] = encode_i(imm, rs1, rv_isa_pkg::F3_OR, rd, rv_isa_pkg::OPC_OP_IMM);
				9:  prog[p] = encode_i(imm, rs1, rv_isa_pkg::F3_XOR, rd, rv_isa_pkg::OPC_OP_IMM);
				10: prog[p] = encode_i(imm, rs1, rv_isa_pkg::F3_SLT, rd, rv_isa_pkg::OPC_OP_IMM);
				11, 12: prog[p] = encode_s(word_offset(), rs2, 5'd0);
				default: prog[p] = encode_i(word_offset(), 5'd0, rv_isa_pkg::F3_LW_SW, rd,
					rv_isa_pkg::OPC_LOAD);
			endcase
		end
		// final state of x0..x7
		for (int r = 0; r < 8; r++) begin
			prog[PROG_LEN - 8 + r] = encode_s(word_offset(), 5'(r), 5'd0);
		end
	endtask

	// ------------------------------------------------------------------------
	// fetch order, store checks and request hold checks sampled mid-cycle

	always @(negedge clk) begin
		if (rst_n) begin
			if (imem_valid && imem_ready) begin
				check_val("fetch addr", fetch_pc, {2'b00, imem_addr});
				fetch_pc = fetch_pc + 1;
			end
			if (hold_prev) begin
				check_val("dmem hold valid", 32'd1, {31'd0, dmem_valid});
				check_val("dmem hold addr", prev_addr, {2'b00, dmem_addr});
				check_val("dmem hold write", prev_write, {31'd0, dmem_write});
				check_val("dmem hold wdata", prev_wdata, dmem_wdata);
			end
			if (dmem_valid && dmem_ready && dmem_write) begin
				if (store_idx >= exp_addr.size()) begin
					$display("store to word %h after the last expected store", dmem_addr);
					$display("Done: errors found");
					$fatal(1);
				end else begin
					check_val($sformatf("store %0d addr", store_idx),
						{2'b00, exp_addr[store_idx]}, {2'b00, dmem_addr});
					check_val($sformatf("store %0d data", store_idx),
						exp_data[store_idx], dmem_wdata);
					store_idx = store_idx + 1;
				end
			end
			hold_prev  = dmem_valid && !dmem_ready;
			prev_addr  = {2'b00, dmem_addr};
			prev_write = {31'd0, dmem_write};
			prev_wdata = dmem_wdata;
		end
	end

	initial begin
		int unsigned seed_ret;
		int          n_exp;
		rst_n = 1'b0;
		seed_ret = $urandom(32'h2a77);
		build_program();
		for (int k = 0; k < DMEM_WORDS; k++) begin
			dmem[k] = $urandom;
			init_dmem[k] = dmem[k];
		end
		run_model();
		n_exp = exp_addr.size();
		repeat (16) begin
			@(negedge clk);
			check_val("reset imem_valid", 32'd0, {31'd0, imem_valid});
			check_val("reset dmem_valid", 32'd0, {31'd0, dmem_valid});
		end
		@(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_val("after reset imem_valid", 32'd0, {31'd0, imem_valid});
		check_val("after reset dmem_valid", 32'd0, {31'd0, dmem_valid});
		wait (store_idx == n_exp);
		// room for any stray store
		repeat (20) @(posedge clk);
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/alu.sv
// alu module: add, sub, and, or, xor and signed set-less-than
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  core_pkg::alu_op_e         op,
	input  logic [core_pkg::XLEN-1:0] a,
	input  logic [core_pkg::XLEN-1:0] b,
	output logic [core_pkg::XLEN-1:0] result
);

	logic lt;

	assign lt = ($signed(a) < $signed(b));

	always_comb begin
		case (op)
			core_pkg::ALU_ADD: result = a + b;
			core_pkg::ALU_SUB: result = a - b;
			core_pkg::ALU_AND: result = a & b;
			core_pkg::ALU_OR:  result = a | b;
			core_pkg::ALU_XOR: result = a ^ b;
			core_pkg::ALU_SLT: begin
				result = '0;
				result[0] = lt;
			end
			default: result = a + b;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/core_pkg.sv
// datapath widths, fetch queue sizing, fetch item struct and ALU op enum
`default_nettype none

package core_pkg;

	localparam int XLEN   = 32;
	// word address, byte offset dropped
	localparam int ADDR_W = 30;
	localparam int REG_AW = 5;

	// ------------------------------------------------------------------------
	// fetch queue

	localparam int FQ_DEPTH = 4;
	localparam int FQ_PTR_W = $clog2(FQ_DEPTH);
	localparam int FQ_CNT_W = $clog2(FQ_DEPTH + 1);
	localparam logic [FQ_CNT_W-1:0] FQ_FULL_CNT = FQ_CNT_W'(FQ_DEPTH);

	typedef struct packed {
		logic [ADDR_W-1:0] pc;
		logic [XLEN-1:0]   instr;
	} fetch_item_t;

	// ------------------------------------------------------------------------
	// ALU

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} alu_op_e;

endpackage

`default_nettype wire

// File: verilog/exec_unit.sv
// exec_unit module with decode, operand select, data port sequencing and write-back
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  logic                        clk,
	input  logic                        rst_n,
	fetch_if.exec_side                  deq,
	output logic                        dmem_valid,
	input  logic                        dmem_ready,
	output logic                        dmem_write,
	output logic [core_pkg::ADDR_W-1:0] dmem_addr,
	output logic [core_pkg::XLEN-1:0]   dmem_wdata,
	input  logic [core_pkg::XLEN-1:0]   dmem_rdata
);

	rv_isa_pkg::instr_u        ins;
	logic                      is_op;
	logic                      is_imm;
	logic                      is_load;
	logic                      is_store;
	logic                      is_mem;
	logic                      alu_known;
	core_pkg::alu_op_e         alu_op;
	logic [core_pkg::XLEN-1:0] i_imm;
	logic [core_pkg::XLEN-1:0] s_imm;
	logic [core_pkg::XLEN-1:0] rs1_data;
	logic [core_pkg::XLEN-1:0] rs2_data;
	logic [core_pkg::XLEN-1:0] op_b;
	logic [core_pkg::XLEN-1:0] alu_result;
	logic [core_pkg::XLEN-1:0] load_data;
	logic                      mem_busy;
	logic                      pop;
	logic                      wr_en;
	logic [core_pkg::XLEN-1:0] wr_data;

	// ------------------------------------------------------------------------
	// decode

	assign ins      = deq.item.instr;
	assign is_op    = (ins.r.opcode == rv_isa_pkg::OPC_OP);
	assign is_imm   = (ins.r.opcode == rv_isa_pkg::OPC_OP_IMM);
	assign is_load  = (ins.i.opcode == rv_isa_pkg::OPC_LOAD) &&
	                  (ins.i.funct3 == rv_isa_pkg::F3_LW_SW);
	assign is_store = (ins.s.opcode == rv_isa_pkg::OPC_STORE) &&
	                  (ins.s.funct3 == rv_isa_pkg::F3_LW_SW);
	assign is_mem   = is_load || is_store;

	assign i_imm = {{20{ins.i.imm[11]}}, ins.i.imm};
	assign s_imm = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};

	always_comb begin
		alu_op    = core_pkg::ALU_ADD;
		alu_known = 1'b1;
		// loads and stores keep ADD for the address
		if (is_op || is_imm) begin
			case (ins.r.funct3)
				rv_isa_pkg::F3_ADD_SUB: begin
					if (is_op && ins.r.funct7[rv_isa_pkg::F7_SUB_BIT]) begin
						alu_op = core_pkg::ALU_SUB;
					end
				end
				rv_isa_pkg::F3_SLT: alu_op = core_pkg::ALU_SLT;
				rv_isa_pkg::F3_XOR: alu_op = core_pkg::ALU_XOR;
				rv_isa_pkg::F3_OR:  alu_op = core_pkg::ALU_OR;
				rv_isa_pkg::F3_AND: alu_op = core_pkg::ALU_AND;
				default:            alu_known = 1'b0;
			endcase
		end
	end

	assign op_b = is_op ? rs2_data : (is_store ? s_imm : i_imm);

	reg_file u_reg_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1_addr (ins.r.rs1),
		.rs2_addr (ins.r.rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wr_en    (wr_en),
		.wr_addr  (ins.r.rd),
		.wr_data  (wr_data)
	);

	alu u_alu (
		.op     (alu_op),
		.a      (rs1_data),
		.b      (op_b),
		.result (alu_result)
	);

	// ------------------------------------------------------------------------
	// data port

	// item stays at queue head until dmem_ready
	assign dmem_valid = mem_busy;
	assign dmem_write = mem_busy && is_store;
	assign dmem_addr  = alu_result[core_pkg::XLEN-1:2];
	// byte-reversed lanes on the data port
	assign dmem_wdata = {<<8{rs2_data}};
	assign load_data  = {<<8{dmem_rdata}};

	assign deq.ready = mem_busy ? dmem_ready : (deq.valid && !is_mem);
	assign pop       = deq.valid && deq.ready;

	assign wr_en   = pop && (mem_busy ? is_load : ((is_op || is_imm) && alu_known));
	assign wr_data = mem_busy ? load_data : alu_result;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_busy <= 1'b0;
		end else if (!mem_busy && deq.valid && is_mem) begin
			mem_busy <= 1'b1;
		end else if (mem_busy && dmem_ready) begin
			mem_busy <= 1'b0;
		end
	end

	a_dmem_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		dmem_valid && !dmem_ready |=>
			dmem_valid && $stable(dmem_addr) && $stable(dmem_write) && $stable(dmem_wdata)
	);

	// head item kept in the queue and unchanged until taken
	a_head_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		deq.valid && !deq.ready |=> deq.count != '0 && $stable(deq.item)
	);

endmodule

`default_nettype wire

// File: verilog/fetch_if.sv
// fetch_if interface from fetch queue to execute unit, with modports
`timescale 1ns/1ps
`default_nettype none

interface fetch_if;

	logic                          valid;
	logic                          ready;
	core_pkg::fetch_item_t         item;
	// entries held in the queue
	logic [core_pkg::FQ_CNT_W-1:0] count;

	modport queue_side (
		output valid,
		output item,
		output count,
		input  ready
	);

	modport exec_side (
		input  valid,
		input  item,
		input  count,
		output ready
	);

endinterface

`default_nettype wire

// File: verilog/fetch_queue.sv
// fetch_queue module: circular FIFO of fetch items between fetch and execute
`timescale 1ns/1ps
`default_nettype none

module fetch_queue (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  push_valid,
	output logic                  push_ready,
	input  core_pkg::fetch_item_t push_item,
	fetch_if.queue_side           deq
);

	core_pkg::fetch_item_t         mem [core_pkg::FQ_DEPTH];
	logic [core_pkg::FQ_PTR_W-1:0] wr_ptr;
	logic [core_pkg::FQ_PTR_W-1:0] rd_ptr;
	logic [core_pkg::FQ_CNT_W-1:0] count;
	logic                          push_fire;
	logic                          pop_fire;

	assign push_ready = (count != core_pkg::FQ_FULL_CNT);
	assign push_fire  = push_valid && push_ready;
	assign pop_fire   = deq.valid && deq.ready;

	// head entry, visible from the cycle after its push
	assign deq.valid = (count != '0);
	assign deq.item  = mem[rd_ptr];
	assign deq.count = count;

	always_ff @(posedge clk) begin
		if (push_fire) begin
			mem[wr_ptr] <= push_item;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_fire) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_fire) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push_fire, pop_fire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// fetch side must see push_ready low when full
	a_no_push_full: assert property (
		@(posedge clk) disable iff (!rst_n)
		count == core_pkg::FQ_FULL_CNT |-> !push_valid
	);

endmodule

`default_nettype wire

// File: verilog/fetch_unit.sv
// fetch_unit module with word pc and sequential instruction port requests
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  logic                        clk,
	input  logic                        rst_n,
	output logic                        imem_valid,
	input  logic                        imem_ready,
	output logic [core_pkg::ADDR_W-1:0] imem_addr,
	input  logic [core_pkg::XLEN-1:0]   imem_rdata,
	output logic                        push_valid,
	input  logic                        push_ready,
	output core_pkg::fetch_item_t       push_item
);

	logic [core_pkg::ADDR_W-1:0] pc;
	logic                        run;
	logic                        fire;

	// request only while the queue has room
	assign imem_valid = run && push_ready;
	assign imem_addr  = pc;
	assign fire       = imem_valid && imem_ready;

	// data arrives with the handshake and goes straight to the queue
	assign push_valid      = fire;
	assign push_item.pc    = pc;
	assign push_item.instr = imem_rdata;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			run <= 1'b0;
			pc  <= '0;
		end else begin
			run <= 1'b1;
			if (fire) begin
				pc <= pc + 1'b1;
			end
		end
	end

	// a stalled request is not withdrawn
	a_imem_addr_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		imem_valid && !imem_ready |=> imem_valid && $stable(imem_addr)
	);

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
// reg_file module: 32 x XLEN registers, two async reads, one write, x0 fixed
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [core_pkg::REG_AW-1:0] rs1_addr,
	input  logic [core_pkg::REG_AW-1:0] rs2_addr,
	output logic [core_pkg::XLEN-1:0]   rs1_data,
	output logic [core_pkg::XLEN-1:0]   rs2_data,
	input  logic                        wr_en,
	input  logic [core_pkg::REG_AW-1:0] wr_addr,
	input  logic [core_pkg::XLEN-1:0]   wr_data
);

	logic [core_pkg::XLEN-1:0] regs [2**core_pkg::REG_AW];

	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**core_pkg::REG_AW; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			// x0 never written, so it reads zero
			regs[wr_addr] <= wr_data;
		end
	end

endmodule

`default_nettype wire

// File: verilog/rv_core_top.sv
// rv_core_top module: fetch unit, fetch queue and execute unit with plain ports
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
	input  logic                        clk,
	input  logic                        rst_n,
	output logic                        imem_valid,
	input  logic                        imem_ready,
	output logic [core_pkg::ADDR_W-1:0] imem_addr,
	input  logic [core_pkg::XLEN-1:0]   imem_rdata,
	output logic                        dmem_valid,
	input  logic                        dmem_ready,
	output logic                        dmem_write,
	output logic [core_pkg::ADDR_W-1:0] dmem_addr,
	output logic [core_pkg::XLEN-1:0]   dmem_wdata,
	input  logic [core_pkg::XLEN-1:0]   dmem_rdata
);

	logic                  push_valid;
	logic                  push_ready;
	core_pkg::fetch_item_t push_item;

	fetch_if fq_if ();

	fetch_unit u_fetch (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_valid (imem_valid),
		.imem_ready (imem_ready),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.push_valid (push_valid),
		.push_ready (push_ready),
		.push_item  (push_item)
	);

	fetch_queue u_queue (
		.clk        (clk),
		.rst_n      (rst_n),
		.push_valid (push_valid),
		.push_ready (push_ready),
		.push_item  (push_item),
		.deq        (fq_if.queue_side)
	);

	exec_unit u_exec (
		.clk        (clk),
		.rst_n      (rst_n),
		.deq        (fq_if.exec_side),
		.dmem_valid (dmem_valid),
		.dmem_ready (dmem_ready),
		.dmem_write (dmem_write),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata)
	);

endmodule

`default_nettype wire

// File: verilog/rv_isa_pkg.sv
// RV32I opcodes, function codes, NOP encoding and instruction format union
`default_nettype none

package rv_isa_pkg;

	// major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	localparam logic [2:0] F3_LW_SW   = 3'b010;

	// bit 30 of the word, inside funct7
	localparam int F7_SUB_BIT = 5;

	// addi x0, x0, 0
	localparam logic [31:0] NOP_WORD = 32'h0000_0013;

	// ------------------------------------------------------------------------
	// field layouts

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} instr_r_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} instr_i_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} instr_s_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
		instr_s_t s;
	} instr_u;

endpackage

`default_nettype wire
